// ==== mac_consts.svh ====
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// array shape
`define NUM_LANES 4

// operand and multiplier widths
`define OP_W 8
`define HALF_W 4

// per-lane B register file
`define B_DEPTH 4
`define B_AW 2

// sequencer slot table
`define SLOT_DEPTH 4
`define SLOT_AW 2
`define SHIFT_MODE_W 2

`define ACC_W 20 // holds a full 16 bit product plus headroom

// limit + 4 slots of 7 bits + base limit + step
`define CFG_LEN 34

`endif

// ==== mac_ctrl_pkg.sv ====
`include "mac_consts.svh"

package mac_ctrl_pkg;

	// left shift applied to a partial product
	typedef enum logic [`SHIFT_MODE_W-1:0] {
		SHIFT_0  = 2'd0,
		SHIFT_4  = 2'd1,
		SHIFT_8  = 2'd2,
		SHIFT_12 = 2'd3
	} shift_mode_e;

	// one pass worth of lane control, also the slot table entry layout
	typedef struct packed {
		logic                a_s; // 1 selects high nibble of A
		logic                b_s; // 1 selects high nibble of B
		logic [`B_AW-1:0]    b_addr; // increment in the table, absolute on the output
		shift_mode_e         shifter_mode;
		logic                acc_mode; // 0 load, 1 add
	} mac_ctrl_t;

	// layout of the configuration chain, config_in enters at bit 0
	typedef struct packed {
		logic [`B_AW-1:0]                 step;
		logic [`B_AW-1:0]                 base_limit; // kept for chain layout only
		mac_ctrl_t [`SLOT_DEPTH-1:0]      slots;
		logic [`SLOT_AW-1:0]              limit;
	} seq_cfg_t;

endpackage

// ==== mac_data_pkg.sv ====
`include "mac_consts.svh"

package mac_data_pkg;

	typedef logic [`OP_W-1:0] operand_t;

	// A operands for every lane, lane 0 in the low byte
	typedef operand_t [`NUM_LANES-1:0] a_bundle_t;

	// one write into one lane's B file
	typedef struct packed {
		logic [$clog2(`NUM_LANES)-1:0] lane;
		logic [`B_AW-1:0]              addr;
		operand_t                      data;
	} b_write_t;

	typedef logic [`ACC_W-1:0] lane_sum_t;

	typedef lane_sum_t [`NUM_LANES-1:0] lane_sums_t;

	typedef logic [7:0] round_count_t;

	// what the collector hands out after each round
	typedef struct packed {
		lane_sums_t   sums;
		round_count_t round_count;
	} result_t;

endpackage

// ==== mac_sequencer.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_sequencer
	import mac_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  logic      hp_en,

	output mac_ctrl_t ctrl,
	output logic      round_done,

	input  logic      config_en,
	input  logic      config_in,
	output logic      config_out
);

	seq_cfg_t            cfg_q;
	logic [`SLOT_AW-1:0] slot_cnt;
	logic [`B_AW-1:0]    b_base;
	logic                last_slot;
	mac_ctrl_t           slot;

	// configuration shift chain
	// first bit in travels furthest, so it ends in the step field
	always_ff @(posedge clk) begin
		if (config_en) begin
			cfg_q <= {cfg_q[`CFG_LEN-2:0], config_in};
		end
	end

	assign config_out = cfg_q[`CFG_LEN-1]; // feeds the next array

	assign last_slot = (slot_cnt == cfg_q.limit);
	assign round_done = hp_en && last_slot;

	// slot counter and B base
	always_ff @(posedge clk) begin
		if (reset) begin
			slot_cnt <= '0;
			b_base <= '0;
		end else if (hp_en) begin
			if (last_slot) begin
				slot_cnt <= '0;
				b_base <= b_base + cfg_q.step; // wraps at B_DEPTH
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end
		end
	end

	// control word for the current pass
	always_comb begin
		slot = cfg_q.slots[slot_cnt];
		ctrl = slot;
		ctrl.b_addr = b_base + slot.b_addr; // base plus slot increment
	end

endmodule

// ==== operand_feeder.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module operand_feeder
	import mac_data_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  a_load,
	input  a_bundle_t             a_in,

	input  logic                  b_wr_en,
	input  b_write_t              b_wr,

	output a_bundle_t             a_ops,
	output logic [`NUM_LANES-1:0] b_we,
	output logic [`B_AW-1:0]      b_addr_w,
	output operand_t              b_data_w
);

	logic [`NUM_LANES-1:0] lane_sel;

	// one-hot lane decode
	always_comb begin
		lane_sel = '0;
		lane_sel[b_wr.lane] = 1'b1;
	end

	// A operand registers
	always_ff @(posedge clk) begin
		if (a_load) begin
			a_ops <= a_in;
		end
	end

	// B write strobe, one lane at a time
	always_ff @(posedge clk) begin
		if (reset) begin
			b_we <= '0;
		end else begin
			b_we <= b_wr_en ? lane_sel : '0;
		end
	end

	// shared address and data for all lanes
	always_ff @(posedge clk) begin
		if (b_wr_en) begin
			b_addr_w <= b_wr.addr;
			b_data_w <= b_wr.data;
		end
	end

endmodule

// ==== mac_lane.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_lane
	import mac_ctrl_pkg::*;
	import mac_data_pkg::*;
(
	input  logic             clk,
	input  logic             reset,

	input  logic             hp_en,
	input  mac_ctrl_t        ctrl,
	input  operand_t         a_op,

	input  logic             b_we,
	input  logic [`B_AW-1:0] b_addr_w,
	input  operand_t         b_data_w,

	output lane_sum_t        sum
);

	operand_t               b_file [`B_DEPTH];
	operand_t               b_word;
	logic [`HALF_W-1:0]     a_nib;
	logic [`HALF_W-1:0]     b_nib;
	logic [2*`HALF_W-1:0]   prod;
	lane_sum_t              prod_ext;
	lane_sum_t              shifted;
	lane_sum_t              acc;

	// B register file
	always_ff @(posedge clk) begin
		if (b_we) begin
			b_file[b_addr_w] <= b_data_w;
		end
	end

	assign b_word = b_file[ctrl.b_addr];

	// nibble select
	assign a_nib = ctrl.a_s ? a_op[`OP_W-1:`HALF_W] : a_op[`HALF_W-1:0];
	assign b_nib = ctrl.b_s ? b_word[`OP_W-1:`HALF_W] : b_word[`HALF_W-1:0];

	assign prod = a_nib * b_nib; // 4x4 unsigned
	assign prod_ext = lane_sum_t'(prod);

	always_comb begin
		case (ctrl.shifter_mode)
			SHIFT_0:  shifted = prod_ext;
			SHIFT_4:  shifted = prod_ext << 4;
			SHIFT_8:  shifted = prod_ext << 8;
			SHIFT_12: shifted = prod_ext << 12;
			default:  shifted = prod_ext;
		endcase
	end

	// load or accumulate, one pass per hp_en
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (hp_en) begin
			if (ctrl.acc_mode) begin
				acc <= acc + shifted;
			end else begin
				acc <= shifted;
			end
		end
	end

	assign sum = acc;

endmodule

// ==== result_collector.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module result_collector
	import mac_data_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	input  logic       round_done,
	input  lane_sums_t sums,

	output result_t    result,
	output logic       result_valid
);

	logic         done_q;
	lane_sums_t   sums_q;
	round_count_t count_q;

	// lanes update on the round_done edge, so look one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
		end else begin
			done_q <= round_done;
		end
	end

	always_ff @(posedge clk) begin
		if (done_q) begin
			sums_q <= sums;
		end
	end

	// round counter and valid pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= done_q;
			if (done_q) begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	assign result.sums = sums_q;
	assign result.round_count = count_q;

endmodule

// ==== mac_array_top.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_array_top
	import mac_ctrl_pkg::*;
	import mac_data_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  logic      hp_en,

	input  logic      config_en,
	input  logic      config_in,
	output logic      config_out,

	input  logic      a_load,
	input  a_bundle_t a_in,

	input  logic      b_wr_en,
	input  b_write_t  b_wr,

	output result_t   result,
	output logic      result_valid
);

	mac_ctrl_t             ctrl;
	logic                  round_done;
	a_bundle_t             a_ops;
	logic [`NUM_LANES-1:0] b_we;
	logic [`B_AW-1:0]      b_addr_w;
	operand_t              b_data_w;
	lane_sums_t            sums;

	mac_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.hp_en      (hp_en),
		.ctrl       (ctrl),
		.round_done (round_done),
		.config_en  (config_en),
		.config_in  (config_in),
		.config_out (config_out)
	);

	operand_feeder u_feeder (
		.clk      (clk),
		.reset    (reset),
		.a_load   (a_load),
		.a_in     (a_in),
		.b_wr_en  (b_wr_en),
		.b_wr     (b_wr),
		.a_ops    (a_ops),
		.b_we     (b_we),
		.b_addr_w (b_addr_w),
		.b_data_w (b_data_w)
	);

	// same control word broadcast to every lane
	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		mac_lane u_lane (
			.clk      (clk),
			.reset    (reset),
			.hp_en    (hp_en),
			.ctrl     (ctrl),
			.a_op     (a_ops[i]),
			.b_we     (b_we[i]),
			.b_addr_w (b_addr_w),
			.b_data_w (b_data_w),
			.sum      (sums[i])
		);
	end

	result_collector u_collector (
		.clk          (clk),
		.reset        (reset),
		.round_done   (round_done),
		.sums         (sums),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== mac_array_assertions.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_array_assertions
	import mac_ctrl_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input logic      hp_en,
	input mac_ctrl_t ctrl,
	input logic      round_done,
	input logic      result_valid
);

	// single cycle pulse
	assert property (@(posedge clk) disable iff (reset)
		result_valid |-> !$past(result_valid))
		else $error("result_valid high for two cycles in a row");

	// collector pipeline is two edges deep
	assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && !$past(reset, 2) |-> (result_valid == $past(round_done, 2)))
		else $error("result_valid does not follow round_done by two edges");

	assert property (@(posedge clk) disable iff (reset)
		hp_en |-> !$isunknown(ctrl))
		else $error("ctrl unknown while hp_en is high");

endmodule

bind mac_array_top mac_array_assertions u_assertions (
	.clk          (clk),
	.reset        (reset),
	.hp_en        (hp_en),
	.ctrl         (ctrl),
	.round_done   (round_done),
	.result_valid (result_valid)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== tb_mac_array.sv ====
`timescale 1ns/1ps
`include "mac_consts.svh"

module tb_mac_array
	import mac_ctrl_pkg::*;
	import mac_data_pkg::*;
();

	logic      clk;
	logic      gen_reset;
	logic      tb_reset;
	logic      dut_reset;
	logic      hp_en;
	logic      config_en;
	logic      config_in;
	logic      config_out;
	logic      a_load;
	a_bundle_t a_in;
	logic      b_wr_en;
	b_write_t  b_wr;
	result_t   result;
	logic      result_valid;

	integer    seed = 32'h275e_d3b4;
	integer    fd;
	integer    line_count = 0;
	logic      lines_counted = 1'b0;
	int        valid_count = 0;
	int        expected_pulses = 0;
	int        cur_limit = 0;
	logic      gaps_on = 1'b0;
	logic      cfg_known = 1'b0; // chain holds X until the first load
	seq_cfg_t  prev_cfg;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.reset (gen_reset)
	);

	assign dut_reset = gen_reset | tb_reset;

	mac_array_top u_dut (
		.clk          (clk),
		.reset        (dut_reset),
		.hp_en        (hp_en),
		.config_en    (config_en),
		.config_in    (config_in),
		.config_out   (config_out),
		.a_load       (a_load),
		.a_in         (a_in),
		.b_wr_en      (b_wr_en),
		.b_wr         (b_wr),
		.result       (result),
		.result_valid (result_valid)
	);

	// every result pulse seen
	always @(negedge clk) begin
		if (result_valid === 1'b1) begin
			valid_count <= valid_count + 1;
		end
	end

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			fail_run();
		end
	endtask

	// old chain contents come out of config_out while the new ones go in
	task automatic load_config(input seq_cfg_t cfg);
		for (int k = `CFG_LEN - 1; k >= 0; k--) begin
			@(posedge clk);
			config_en <= 1'b1;
			config_in <= cfg[k];
			@(negedge clk);
			if (cfg_known) begin
				check(config_out, prev_cfg[k], "config_out");
			end
		end
		@(posedge clk);
		config_en <= 1'b0;
		prev_cfg = cfg;
		cfg_known = 1'b1;
	endtask

	task automatic run_round();
		int gap;
		int cycles;
		for (int p = 0; p <= cur_limit; p++) begin
			gap = 0;
			if (gaps_on) begin
				gap = $unsigned($random(seed)) % 4;
			end
			repeat (gap) begin
				@(posedge clk);
				hp_en <= 1'b0;
			end
			@(posedge clk);
			hp_en <= 1'b1;
		end
		@(posedge clk);
		hp_en <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (result_valid !== 1'b1 && cycles < 20) begin
			cycles++;
			@(negedge clk);
		end
		if (result_valid !== 1'b1) begin
			$display("result_valid never came after the last pass of a round");
			fail_run();
		end
		expected_pulses++;
		check(cycles, 1, "result_valid latency");
		@(negedge clk);
		check(result_valid, 0, "result_valid pulse width");
		check(valid_count, expected_pulses, "result_valid pulse count");
	endtask

	// a few passes and a reset before the round ends
	task automatic reset_mid_round(input int passes);
		for (int p = 0; p < passes; p++) begin
			@(posedge clk);
			hp_en <= 1'b1;
		end
		@(posedge clk);
		hp_en <= 1'b0;
		tb_reset <= 1'b1;
		repeat (2) @(posedge clk);
		tb_reset <= 1'b0;
		@(negedge clk);
		check(result_valid, 0, "result_valid after reset");
		check(result.round_count, 0, "round_count after reset");
		for (int i = 0; i < `NUM_LANES; i++) begin
			check(u_dut.sums[i], 0, $sformatf("lane %0d accumulator after reset", i));
		end
		check(valid_count, expected_pulses, "result_valid pulse count");
	endtask

	initial begin : main
		logic [8*128-1:0] line_buf;
		logic [7:0]       cmd;
		logic [31:0]      v [6];
		integer           r;
		seq_cfg_t         cfg;
		a_bundle_t        a_val;
		b_write_t         w;

		tb_reset = 1'b0;
		hp_en = 1'b0;
		config_en = 1'b0;
		config_in = 1'b0;
		a_load = 1'b0;
		a_in = '0;
		b_wr_en = 1'b0;
		b_wr = '0;

		fd = $fopen("mac_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open mac_stimulus.txt");
			fail_run();
		end
		while ($fgets(line_buf, fd) != 0) begin
			line_count++;
		end
		$fclose(fd);
		lines_counted = 1'b1;
		fd = $fopen("mac_stimulus.txt", "r");

		@(posedge clk);
		while (gen_reset !== 1'b0) begin
			@(posedge clk);
		end

		r = $fscanf(fd, " %c", cmd);
		while (r == 1) begin
			case (cmd)
				"#": r = $fgets(line_buf, fd);
				"C": begin
					r = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
					cfg = '0;
					cfg.limit = v[0][`SLOT_AW-1:0];
					for (int i = 0; i < `SLOT_DEPTH; i++) begin
						cfg.slots[i] = mac_ctrl_t'(v[i+1][6:0]);
					end
					cfg.step = v[5][`B_AW-1:0];
					load_config(cfg);
					cur_limit = v[0];
				end
				"B": begin
					r = $fscanf(fd, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
					for (int i = 0; i < `NUM_LANES; i++) begin
						w.lane = i;
						w.addr = v[0][`B_AW-1:0];
						w.data = v[i+1][`OP_W-1:0];
						@(posedge clk);
						b_wr_en <= 1'b1;
						b_wr <= w;
					end
					@(posedge clk);
					b_wr_en <= 1'b0;
				end
				"A": begin
					r = $fscanf(fd, "%h %h %h %h", v[0], v[1], v[2], v[3]);
					for (int i = 0; i < `NUM_LANES; i++) begin
						a_val[i] = v[i][`OP_W-1:0];
					end
					@(posedge clk);
					a_load <= 1'b1;
					a_in <= a_val;
					@(posedge clk);
					a_load <= 1'b0;
				end
				"G": begin
					r = $fscanf(fd, "%d", v[0]);
					gaps_on = v[0][0];
				end
				"R": begin
					r = $fscanf(fd, "%d %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
					for (int n = 0; n < v[0]; n++) begin
						run_round();
					end
					for (int i = 0; i < `NUM_LANES; i++) begin
						check(result.sums[i], v[i+1], $sformatf("lane %0d sum", i));
					end
					check(result.round_count, v[5], "round_count");
				end
				"X": begin
					r = $fscanf(fd, "%d", v[0]);
					reset_mid_round(v[0]);
				end
				default: begin
					$display("unknown command %c in mac_stimulus.txt", cmd);
					fail_run();
				end
			endcase
			r = $fscanf(fd, " %c", cmd);
		end
		$fclose(fd);
		$display("all tests passed");
		$finish;
	end

	// budget grows with the stimulus file
	initial begin : watchdog
		wait (lines_counted);
		repeat (line_count * 200) @(posedge clk);
		$display("watchdog timeout, the run did not finish in %0d cycles", line_count * 200);
		fail_run();
	end

endmodule

// ==== mac_stimulus.txt ====
# C limit slot0 slot1 slot2 slot3 step, B addr lane0..lane3, A lane0..lane3, G gaps 0/1
# R rounds sum0 sum1 sum2 sum3 round_count, X passes before reset; rounds/passes/G decimal
C 3 00 43 23 65 0
B 0 12 34 ff 80
B 1 05 a7 3c e1
B 2 9b 01 66 7f
B 3 c4 58 0d ff
A 1d 56 ff 23
R 1 020a 1178 fe01 1180 01
C 3 00 43 23 65 1
R 1 020a 1178 fe01 1180 02
R 1 0091 381a 3bc4 1ec3 03
R 1 118f 0056 659a 115d 04
R 1 1634 1d90 0cf3 22dd 05
R 1 020a 1178 fe01 1180 06
G 1
R 1 0091 381a 3bc4 1ec3 07
R 1 118f 0056 659a 115d 08
G 0
C 0 00 43 23 65 0
R 2 0034 0030 00c3 002d 0a
C 3 00 43 23 65 0
X 2
R 1 020a 1178 fe01 1180 01

// ==== project.f ====
+incdir+.
mac_ctrl_pkg.sv
mac_data_pkg.sv
mac_sequencer.sv
operand_feeder.sv
mac_lane.sv
result_collector.sv
mac_array_top.sv
mac_array_assertions.sv
tb_clock_gen.sv
tb_mac_array.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mac_array
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
